// ==== rtl/seSound_config.svh ====
// Channel loader constants: channel count, page size and stride, channel shift, buffer depth
`ifndef SE_SOUND_CONFIG_SVH
`define SE_SOUND_CONFIG_SVH

// ------------------------------
// Channel set
// ------------------------------
`define SE_CH_NUM       5           // Sound channels fed from ROM

// ------------------------------
// ROM page layout
// ------------------------------
// Each request pulls one page
`define SE_PAGE_BYTES   16          // Bytes per page request
`define SE_PAGE_STRIDE  32'h800     // One 11-bit column field
`define SE_CH_SHIFT     21          // Channel field position in address

// ------------------------------
// Channel buffer
// ------------------------------
`define SE_BUF_DEPTH    32          // Sample FIFO words

`endif

// ==== rtl/seSoundPkg.sv ====
// Loader types: width typedefs, ROM and channel bus structs, reader state enum
`include "seSound_config.svh"

package seSoundPkg;

    // ------------------------------
    // Meaningful widths
    // ------------------------------
    typedef logic [26:0]            romAddr_t;  // Block, page, column 10:0
    typedef logic [7:0]             romByte_t;  // Flash data byte
    typedef logic [15:0]            sample_t;   // Sound sample, low byte first in ROM
    typedef logic [2:0]             chIdx_t;    // Channel number
    typedef logic [`SE_CH_NUM-1:0]  chMask_t;   // One bit per channel

    // ------------------------------
    // Bus payloads
    // ------------------------------
    typedef struct packed {
        romAddr_t   addr;           // Page start, always a read
    } romCmd_t;

    typedef struct packed {
        romByte_t   data;
    } romData_t;

    // Reader to buffer link
    typedef struct packed {
        romByte_t   data;
        logic       last;           // Final byte of the page
    } chByte_t;

    typedef struct packed {
        chIdx_t     ch;             // Source channel tag
        sample_t    sample;
    } chSample_t;

    // Page request sequence
    typedef enum logic [1:0] {
        stIdle,
        stReq,
        stRecv
    } readerState_t;

endpackage

// ==== rtl/seRomReader.sv ====
// ROM reader: round-robin channel pick, per-channel page addressing, byte routing
`timescale 1ns/1ps
`include "seSound_config.svh"

module seRomReader import seSoundPkg::*;
(
    input  logic                        iSysClk,
    input  logic                        rstN,
    input  chMask_t                     chEnable,       // Channels wanted by game state
    input  chMask_t                     pageRoom,       // Buffer can take a full page
    output romCmd_t                     romCmd,
    output logic                        romCmdValid,
    input  logic                        romCmdReady,
    input  romData_t                    romData,
    input  logic                        romDataValid,   // No ready, every beat taken
    output chByte_t [`SE_CH_NUM-1:0]    chByte,
    output chMask_t                     chByteValid     // One-hot on selected channel
);

    localparam int chNum = `SE_CH_NUM;
    localparam int pageW = `SE_CH_SHIFT - $clog2(`SE_PAGE_STRIDE);  // Page field bits
    localparam int byteW = $clog2(`SE_PAGE_BYTES);

    readerState_t       state;
    chIdx_t             selCh;                  // Channel of page in flight
    chIdx_t             rrPtr;                  // Search start
    logic [pageW-1:0]   pageCnt [chNum];        // Next page per channel
    logic [byteW-1:0]   byteCnt;
    chMask_t            eligible;
    chIdx_t             pickCh;
    logic               pickAny;
    logic               lastByte;

    function automatic chIdx_t nextCh(input chIdx_t c);
        return (c == chIdx_t'(chNum - 1)) ? '0 : c + 1'b1;
    endfunction

    // ------------------------------
    // Channel pick
    // ------------------------------
    always_comb
    begin
        int idx;
        eligible = chEnable & pageRoom;
        pickCh   = '0;
        pickAny  = 1'b0;
        for (int i = 0; i < chNum; i++)
        begin
            idx = int'(rrPtr) + i;
            if (idx >= chNum)
                idx = idx - chNum;              // Wrap around channel set
            if (!pickAny && eligible[idx])
            begin
                pickAny = 1'b1;
                pickCh  = chIdx_t'(idx);
            end
        end
    end

    assign romCmdValid = (state == stReq);
    assign lastByte    = romDataValid && (byteCnt == byteW'(`SE_PAGE_BYTES - 1));

    // ------------------------------
    // Request FSM
    // ------------------------------
    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            state   <= stIdle;
            selCh   <= '0;
            rrPtr   <= '0;
            byteCnt <= '0;
            for (int c = 0; c < chNum; c++)
                pageCnt[c] <= '0;
        end
        else
        begin
            case (state)
                stIdle:
                begin
                    if (pickAny)
                    begin
                        selCh <= pickCh;
                        rrPtr <= nextCh(pickCh);        // Fairness for next pick
                        state <= stReq;
                    end
                end
                stReq:
                begin
                    if (romCmdReady)
                    begin
                        pageCnt[selCh] <= pageCnt[selCh] + 1'b1;
                        byteCnt        <= '0;
                        state          <= stRecv;
                    end
                end
                stRecv:
                begin
                    if (romDataValid)
                        byteCnt <= byteCnt + 1'b1;
                    if (lastByte)
                        state <= stIdle;                // Page done
                end
                default:
                    state <= stIdle;
            endcase
        end
    end

    // Address captured at pick, held until accepted
    always_ff @(posedge iSysClk)
    begin
        if (state == stIdle && pickAny)
            romCmd.addr <= (romAddr_t'(pickCh) << `SE_CH_SHIFT)
                         + romAddr_t'(pageCnt[pickCh]) * romAddr_t'(`SE_PAGE_STRIDE);
    end

    // ------------------------------
    // Byte routing
    // ------------------------------
    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
            chByteValid <= '0;
        else if (state == stRecv && romDataValid)
            chByteValid <= chMask_t'(1) << selCh;
        else
            chByteValid <= '0;
    end

    always_ff @(posedge iSysClk)
    begin
        if (state == stRecv && romDataValid)
        begin
            chByte[selCh].data <= romData.data;
            chByte[selCh].last <= lastByte;     // Tags end of page
        end
    end

endmodule

// ==== rtl/seChannelBuffer.sv ====
// Channel buffer: byte-pair packing, sample FIFO with output register, page-room flag
`timescale 1ns/1ps
`include "seSound_config.svh"

module seChannelBuffer import seSoundPkg::*;
(
    input  logic        iSysClk,
    input  logic        rstN,
    input  chByte_t     inByte,
    input  logic        inValid,
    output logic        pageRoom,       // Room for one more page
    output sample_t     outSample,
    output logic        outValid,
    input  logic        outReady
);

    localparam int depth     = `SE_BUF_DEPTH;
    localparam int ptrW      = $clog2(depth);
    localparam int pageWords = `SE_PAGE_BYTES / 2;

    // Byte pairing
    romByte_t           lowByte;
    logic               haveLow;        // Low byte held, waiting for high
    logic               inPage;         // Page partly received
    logic               pageStart;
    logic               wrNow;

    // Sample FIFO
    sample_t            mem [depth];
    logic [ptrW:0]      wrPtr;
    logic [ptrW:0]      rdPtr;
    logic [ptrW:0]      fill;
    logic [ptrW:0]      pending;        // Promised words not yet written
    logic [ptrW+1:0]    used;
    logic               fifoEmpty;
    logic               popFifo;

    assign pageStart = inValid && !inPage;
    assign wrNow     = inValid && haveLow;          // High byte completes a sample

    assign fill      = wrPtr - rdPtr;
    assign fifoEmpty = (fill == '0);
    assign popFifo   = !fifoEmpty && (!outValid || outReady);

    // ------------------------------
    // Page room
    // ------------------------------
    // Words on their way count as used
    assign used     = {1'b0, fill} + {1'b0, pending};
    assign pageRoom = (used <= (ptrW + 2)'(depth - pageWords));

    // ------------------------------
    // Pairing and promise
    // ------------------------------
    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            haveLow <= 1'b0;
            inPage  <= 1'b0;
            pending <= '0;
        end
        else
        begin
            if (inValid)
            begin
                haveLow <= !haveLow && !inByte.last;    // Last byte closes pairing
                inPage  <= !inByte.last;
            end
            // Whole page promised on first byte, released per word
            pending <= pending
                     + (pageStart ? (ptrW + 1)'(pageWords) : '0)
                     - {{ptrW{1'b0}}, wrNow};
        end
    end

    // ------------------------------
    // FIFO pointers and output stage
    // ------------------------------
    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            outValid <= 1'b0;
        end
        else
        begin
            if (wrNow)
                wrPtr <= wrPtr + 1'b1;
            if (popFifo)
                rdPtr <= rdPtr + 1'b1;
            if (!outValid || outReady)
                outValid <= !fifoEmpty;         // Refill or drop when consumed
        end
    end

    always_ff @(posedge iSysClk)
    begin
        if (inValid && !haveLow)
            lowByte <= inByte.data;
        if (wrNow)
            mem[wrPtr[ptrW-1:0]] <= {inByte.data, lowByte};     // High byte on top
        if (popFifo)
            outSample <= mem[rdPtr[ptrW-1:0]];
    end

endmodule

// ==== rtl/seChannelDrain.sv ====
// Drain arbiter: round-robin merge of channel FIFOs into one tagged registered stream
`timescale 1ns/1ps
`include "seSound_config.svh"

module seChannelDrain import seSoundPkg::*;
(
    input  logic                        iSysClk,
    input  logic                        rstN,
    input  sample_t [`SE_CH_NUM-1:0]    chSample,
    input  chMask_t                     chValid,
    output chMask_t                     chReady,    // Pop strobe per buffer
    output chSample_t                   outSample,
    output logic                        outValid,
    input  logic                        outReady    // Sound generator back-pressure
);

    localparam int chNum = `SE_CH_NUM;

    chIdx_t     rrPtr;                  // Channel after last grant
    chIdx_t     grantCh;
    logic       grantAny;
    logic       load;                   // Output stage free this cycle

    function automatic chIdx_t nextCh(input chIdx_t c);
        return (c == chIdx_t'(chNum - 1)) ? '0 : c + 1'b1;
    endfunction

    // ------------------------------
    // Arbiter
    // ------------------------------
    always_comb
    begin
        int idx;
        grantCh  = '0;
        grantAny = 1'b0;
        for (int i = 0; i < chNum; i++)
        begin
            idx = int'(rrPtr) + i;
            if (idx >= chNum)
                idx = idx - chNum;
            if (!grantAny && chValid[idx])
            begin
                grantAny = 1'b1;
                grantCh  = chIdx_t'(idx);
            end
        end
    end

    assign load    = !outValid || outReady;
    assign chReady = (load && grantAny) ? (chMask_t'(1) << grantCh) : '0;

    // ------------------------------
    // Output register
    // ------------------------------
    always_ff @(posedge iSysClk or negedge rstN)
    begin
        if (!rstN)
        begin
            rrPtr    <= '0;
            outValid <= 1'b0;
        end
        else if (load)
        begin
            outValid <= grantAny;
            if (grantAny)
                rrPtr <= nextCh(grantCh);
        end
    end

    // Held steady while stalled
    always_ff @(posedge iSysClk)
    begin
        if (load && grantAny)
        begin
            outSample.ch     <= grantCh;
            outSample.sample <= chSample[grantCh];
        end
    end

endmodule

// ==== rtl/seChannelLoad.sv ====
// Channel loader top: ROM reader, per-channel buffers and drain arbiter
`timescale 1ns/1ps
`include "seSound_config.svh"

module seChannelLoad import seSoundPkg::*;
(
    input  logic        iSysClk,
    input  logic        rstN,
    input  chMask_t     chEnable,       // From game state
    output romCmd_t     romCmd,
    output logic        romCmdValid,
    input  logic        romCmdReady,
    input  romData_t    romData,
    input  logic        romDataValid,
    output chSample_t   outSample,      // To sound generator
    output logic        outValid,
    input  logic        outReady
);

    // ------------------------------
    // Internal links
    // ------------------------------
    chByte_t [`SE_CH_NUM-1:0]   chByte;         // Reader to buffers
    chMask_t                    chByteValid;
    chMask_t                    pageRoom;
    sample_t [`SE_CH_NUM-1:0]   bufSample;      // Buffers to drain
    chMask_t                    bufValid;
    chMask_t                    bufReady;

    seRomReader reader_i (
        .iSysClk        (iSysClk),
        .rstN           (rstN),
        .chEnable       (chEnable),
        .pageRoom       (pageRoom),
        .romCmd         (romCmd),
        .romCmdValid    (romCmdValid),
        .romCmdReady    (romCmdReady),
        .romData        (romData),
        .romDataValid   (romDataValid),
        .chByte         (chByte),
        .chByteValid    (chByteValid)
    );

    // One buffer per channel
    for (genvar c = 0; c < `SE_CH_NUM; c++)
    begin : genBuf
        seChannelBuffer buf_i (
            .iSysClk    (iSysClk),
            .rstN       (rstN),
            .inByte     (chByte[c]),
            .inValid    (chByteValid[c]),
            .pageRoom   (pageRoom[c]),
            .outSample  (bufSample[c]),
            .outValid   (bufValid[c]),
            .outReady   (bufReady[c])
        );
    end

    seChannelDrain drain_i (
        .iSysClk    (iSysClk),
        .rstN       (rstN),
        .chSample   (bufSample),
        .chValid    (bufValid),
        .chReady    (bufReady),
        .outSample  (outSample),
        .outValid   (outValid),
        .outReady   (outReady)
    );

endmodule

// ==== verification/seChannelLoadTb.sv ====
// Flash model, stimulus, reference model, checker, watchdog and report for the channel loader
`timescale 1ns/1ps
`include "seSound_config.svh"

module seChannelLoadTb import seSoundPkg::*;
();

    localparam int chNum         = `SE_CH_NUM;
    localparam int pageWords     = `SE_PAGE_BYTES / 2;
    localparam int pageCycles    = 40;      // Pick, command, 16 beats with gaps
    localparam int totalPages    = 100;     // Pages over all tests and drains
    localparam int stallCycles   = 1200;
    localparam int timeoutCycles = 4 * (totalPages * pageCycles + stallCycles) + 2000;
    localparam int drainQuiet    = 20;      // Idle cycles that end a drain
    localparam int modeRandom    = 0;
    localparam int modeLow       = 1;
    localparam int modeHigh      = 2;
    localparam int modeStretch   = 3;

    logic           iSysClk = 1'b0;
    logic           rstN;
    chMask_t        chEnable;
    romCmd_t        romCmd;
    logic           romCmdValid;
    logic           romCmdReady;
    romData_t       romData;
    logic           romDataValid;
    chSample_t      outSample;
    logic           outValid;
    logic           outReady;

    integer         seed = 7;
    logic [31:0]    rnd;
    int             cycleCnt = 0;
    int             readyMode = modeRandom;
    romAddr_t       flashAddr;                  // Next byte of page in flight
    int             bytesLeft = 0;
    int             cmdCnt [chNum] = '{default: 0};
    int             sampleCnt [chNum] = '{default: 0};
    chMask_t        offMask = '0;               // Channels that must stay silent
    logic           holdPending = 1'b0;
    chSample_t      heldSample;
    int             seqErrs = 0;                // Found by the test sequence
    int             chkErrs = 0;                // Found by the checker
    int             testCnt = 0;

    seChannelLoad dut_i (
        .iSysClk        (iSysClk),
        .rstN           (rstN),
        .chEnable       (chEnable),
        .romCmd         (romCmd),
        .romCmdValid    (romCmdValid),
        .romCmdReady    (romCmdReady),
        .romData        (romData),
        .romDataValid   (romDataValid),
        .outSample      (outSample),
        .outValid       (outValid),
        .outReady       (outReady)
    );

    always #50 iSysClk = ~iSysClk;              // 100 ns period

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic romByte_t romByte(input romAddr_t addr);
        int chField;
        chField = int'(addr >> `SE_CH_SHIFT);
        return addr[7:0] ^ romByte_t'(chField * 37);
    endfunction

    // Sample k of channel c with its low byte at an even column
    function automatic sample_t expectSample(input int c, input int k);
        romAddr_t lowAddr;
        lowAddr = (romAddr_t'(c) << `SE_CH_SHIFT)
                + romAddr_t'(k / pageWords) * romAddr_t'(`SE_PAGE_STRIDE)
                + romAddr_t'(2 * (k % pageWords));
        return {romByte(lowAddr + romAddr_t'(1)), romByte(lowAddr)};
    endfunction

    function automatic int totalCmds();
        int sum;
        sum = 0;
        for (int c = 0; c < chNum; c++)
            sum = sum + cmdCnt[c];
        return sum;
    endfunction

    function automatic int totalSamples();
        int sum;
        sum = 0;
        for (int c = 0; c < chNum; c++)
            sum = sum + sampleCnt[c];
        return sum;
    endfunction

    task automatic logError(inout int errs, input string msg);
        $display("error %0t: %s", $time, msg);
        errs = errs + 1;
    endtask

    // ------------------------------
    // Flash model and output sink
    // ------------------------------
    initial
    begin : stimulus
        romCmdReady  = 1'b0;
        romData      = '0;
        romDataValid = 1'b0;
        outReady     = 1'b0;
        forever
        begin
            @(negedge iSysClk);
            rnd = $random(seed);
            if (bytesLeft > 0)
            begin
                romCmdReady  = 1'b0;
                romDataValid = (rnd[3:0] > 4'd2);       // Random gaps between beats
                if (romDataValid)
                begin
                    romData.data = romByte(flashAddr);
                    flashAddr    = flashAddr + romAddr_t'(1);
                    bytesLeft    = bytesLeft - 1;
                end
            end
            else
            begin
                romDataValid = 1'b0;
                romCmdReady  = rnd[4];
                if (romCmdValid && romCmdReady)         // Transfer on next rising edge
                begin
                    flashAddr = romCmd.addr;
                    bytesLeft = `SE_PAGE_BYTES;
                end
            end
            case (readyMode)
                modeRandom: outReady = rnd[5] | rnd[6];  // Three in four
                modeLow:    outReady = 1'b0;
                modeHigh:   outReady = 1'b1;
                default:    outReady = ((cycleCnt % 200) >= 120) && rnd[7];
            endcase
        end
    end

    // ------------------------------
    // Checker
    // ------------------------------
    task automatic checkCommand(input romAddr_t addr);
        int c;
        romAddr_t expAddr;
        c = int'(addr >> `SE_CH_SHIFT);
        if (c >= chNum)
            logError(chkErrs, $sformatf("command address %h has no channel", addr));
        else
        begin
            expAddr = (romAddr_t'(c) << `SE_CH_SHIFT)
                    + romAddr_t'(cmdCnt[c]) * romAddr_t'(`SE_PAGE_STRIDE);
            if (addr != expAddr)
                logError(chkErrs, $sformatf("command address %h, expected %h", addr, expAddr));
            if (offMask[c])
                logError(chkErrs, $sformatf("command for disabled channel %0d", c));
            cmdCnt[c] = cmdCnt[c] + 1;
            // FIFO plus buffer and drain registers
            if (cmdCnt[c] * pageWords - sampleCnt[c] > `SE_BUF_DEPTH + 2)
                logError(chkErrs, $sformatf("channel %0d has %0d words outstanding", c,
                         cmdCnt[c] * pageWords - sampleCnt[c]));
        end
    endtask

    task automatic checkSample(input chSample_t s);
        int c;
        sample_t expVal;
        c = int'(s.ch);
        if (c >= chNum)
            logError(chkErrs, $sformatf("output tag %0d is no channel", c));
        else
        begin
            expVal = expectSample(c, sampleCnt[c]);
            if (offMask[c])
                logError(chkErrs, $sformatf("output from disabled channel %0d", c));
            if (s.sample != expVal)
                logError(chkErrs, $sformatf("channel %0d sample %0d is %h, expected %h",
                         c, sampleCnt[c], s.sample, expVal));
            sampleCnt[c] = sampleCnt[c] + 1;
        end
    endtask

    always @(posedge iSysClk)
    begin : monitor
        if (rstN)
        begin
            if (romCmdValid && romCmdReady)
                checkCommand(romCmd.addr);
            if (holdPending && (!outValid || outSample != heldSample))
                logError(chkErrs, "output changed while stalled");
            holdPending = outValid && !outReady;
            heldSample  = outSample;
            if (outValid && outReady)
                checkSample(outSample);
        end
    end

    // ------------------------------
    // Sequence helpers
    // ------------------------------
    task automatic waitWords(input chMask_t mask, input int words);
        int target [chNum];
        logic done;
        for (int c = 0; c < chNum; c++)
            target[c] = sampleCnt[c] + words;
        done = 1'b0;
        while (!done)
        begin
            @(negedge iSysClk);
            done = 1'b1;
            for (int c = 0; c < chNum; c++)
                if (mask[c] && sampleCnt[c] < target[c])
                    done = 1'b0;
        end
    endtask

    // Stop loading, empty every buffer, compare counts
    task automatic drainAll();
        int quiet;
        chEnable  = '0;
        readyMode = modeHigh;
        quiet     = 0;
        while (quiet < drainQuiet)
        begin
            @(posedge iSysClk);
            if (romCmdValid || bytesLeft != 0 || outValid)
                quiet = 0;
            else
                quiet = quiet + 1;
        end
        @(negedge iSysClk);
        for (int c = 0; c < chNum; c++)
            if (sampleCnt[c] != cmdCnt[c] * pageWords)
                logError(seqErrs, $sformatf("channel %0d drained %0d samples, expected %0d",
                         c, sampleCnt[c], cmdCnt[c] * pageWords));
    endtask

    task automatic endTest(input string name, input int errBefore);
        testCnt = testCnt + 1;
        if (seqErrs + chkErrs == errBefore)
            $display("test %0d %s: ok", testCnt, name);
        else
            $display("test %0d %s: %0d errors", testCnt, name, seqErrs + chkErrs - errBefore);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial
    begin : mainSeq
        int errBefore;
        int cmdMark;
        chMask_t runMask;
        rstN      = 1'b0;
        chEnable  = '0;
        errBefore = 0;
        repeat (2)                                      // Two cycles in reset
        begin
            @(negedge iSysClk);
            if (romCmdValid || outValid)
                logError(seqErrs, "command or output valid during reset");
        end
        rstN     = 1'b1;
        chEnable = '1;
        @(negedge iSysClk);
        if (!romCmdValid)
            logError(seqErrs, "no command on the first cycle after reset");
        if (outValid)
            logError(seqErrs, "output valid before any data arrived");
        endTest("reset", errBefore);

        errBefore = seqErrs + chkErrs;
        waitWords('1, 6 * pageWords);                   // Random ready on all channels
        endTest("page addresses and samples", errBefore);

        errBefore = seqErrs + chkErrs;
        readyMode = modeStretch;
        waitWords('1, 4 * pageWords);
        drainAll();
        endTest("long ready-low stretches", errBefore);

        errBefore = seqErrs + chkErrs;
        chEnable  = '1;
        readyMode = modeLow;
        repeat (stallCycles - 200) @(negedge iSysClk);
        cmdMark = totalCmds();                          // Buffers full by now
        repeat (200) @(negedge iSysClk);
        if (totalCmds() != cmdMark)
            logError(seqErrs, "reader kept issuing commands with all buffers full");
        drainAll();
        endTest("sustained back-pressure", errBefore);

        errBefore = seqErrs + chkErrs;
        runMask    = '1;
        runMask[2] = 1'b0;                              // Channel 2 switched off
        offMask    = ~runMask;
        chEnable   = runMask;
        readyMode  = modeRandom;
        waitWords(runMask, 4 * pageWords);
        drainAll();
        offMask = '0;
        endTest("disabled channel", errBefore);

        $display("tests %0d, errors %0d, samples %0d, commands %0d",
                 testCnt, seqErrs + chkErrs, totalSamples(), totalCmds());
        if (seqErrs + chkErrs == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin : watchdog
        while (cycleCnt < timeoutCycles)
        begin
            @(posedge iSysClk);
            cycleCnt = cycleCnt + 1;
        end
        $display("timeout: tests did not finish within %0d cycles", timeoutCycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/seSoundPkg.sv
rtl/seRomReader.sv
rtl/seChannelBuffer.sv
rtl/seChannelDrain.sv
rtl/seChannelLoad.sv
verification/seChannelLoadTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the channel loader testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module seChannelLoadTb -f filelist.f \
    -o seChannelLoadSim > build.log 2>&1 \
    && ./obj_dir/seChannelLoadSim > sim.log 2>&1 \
    || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Result: FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "No result line found in sim.log"; exit 1; }
echo "Simulation passed"
